/* l1_cache_defines.svh */
`ifndef L1_CACHE_DEFINES_SVH
`define L1_CACHE_DEFINES_SVH

// Four ways
`define L1_WAYS_W 2

// 64 sets
`define L1_LANES_W 6

// 16 words of 32 bits per line, so 64 bytes
`define L1_OFFSET_W 4

// Address bits left over after lane, offset and byte select
`define L1_TAG_W 20

`endif

/* cache_geom_pkg.sv */
`include "l1_cache_defines.svh"

package cache_geom_pkg;

    typedef logic [`L1_TAG_W-1:0] tag_t;
    typedef logic [`L1_WAYS_W-1:0] way_t;
    typedef logic [`L1_LANES_W-1:0] lane_t;
    typedef logic [`L1_OFFSET_W-1:0] offset_t;

    // Physical address split, tag in the top bits
    typedef struct packed {
        tag_t       tag;
        lane_t      lane;
        offset_t    offset;
        logic [1:0] byte_sel;
    } addr_fields_t;

    // Per line bookkeeping
    typedef struct packed {
        logic valid;
        logic dirty;
    } line_state_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FLUSH_ALL
    } ctrl_state_t;

endpackage

/* mem_access_pkg.sv */
`include "l1_cache_defines.svh"

package mem_access_pkg;

    typedef enum logic [2:0] {
        LOAD_BYTE          = 3'd0,
        LOAD_BYTE_UNSIGNED = 3'd1,
        LOAD_HALF          = 3'd2,
        LOAD_HALF_UNSIGNED = 3'd3,
        LOAD_WORD          = 3'd4
    } load_type_t;

    typedef enum logic [1:0] {
        STORE_BYTE = 2'd0,
        STORE_HALF = 2'd1,
        STORE_WORD = 2'd2
    } store_type_t;

    typedef struct packed {
        logic        load;
        logic        store;
        logic [31:0] addr;
        load_type_t  load_type;
        store_type_t store_type;
        logic [31:0] store_data;
    } core_req_t;

    typedef struct packed {
        logic        stall;
        logic        done;
        logic [31:0] load_data;
        logic        load_misaligned;
        logic        load_unknown_type;
        logic        store_misaligned;
        logic        store_unknown_type;
    } core_rsp_t;

    // Burst memory bus, one line per burst
    typedef struct packed {
        logic [31:0]            addr;
        logic [`L1_OFFSET_W:0]  burst_count;
        logic                   read;
        logic                   write;
        logic [31:0]            write_data;
        logic [3:0]             byte_enable;
    } mem_cmd_t;

    typedef struct packed {
        logic        waitrequest;
        logic [31:0] read_data;
        logic        read_data_valid;
    } mem_rsp_t;

endpackage

/* sync_ram.sv */
`timescale 1ns/10ps

module sync_ram #(
    parameter type payload_t = logic [31:0],
    parameter int ELEMENTS_W = 10
) (
    input  logic                  clk,
    input  logic                  read,
    input  logic [ELEMENTS_W-1:0] read_address,
    output payload_t              read_data,
    input  logic                  write,
    input  logic [ELEMENTS_W-1:0] write_address,
    input  payload_t              write_data
);

    payload_t mem [2**ELEMENTS_W];

    // Read returns the old contents on a same-address collision
    always_ff @(posedge clk) begin
        if (write) begin
            mem[write_address] <= write_data;
        end
        if (read) begin
            read_data <= mem[read_address];
        end
    end

    write_address_known: assert property (
        @(posedge clk) write |-> !$isunknown(write_address)
    );

endmodule

/* load_align.sv */
`timescale 1ns/10ps

module load_align (
    input  logic [1:0]                in_word_offset,
    input  mem_access_pkg::load_type_t load_type,
    input  logic [31:0]               data_in,
    output logic [31:0]               data_out,
    output logic                      misaligned,
    output logic                      unknown_type
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = data_in[8*in_word_offset +: 8];
    assign half_sel = data_in[16*in_word_offset[1] +: 16];

    always_comb begin
        data_out     = '0;
        misaligned   = 1'b0;
        unknown_type = 1'b0;
        case (load_type)
            mem_access_pkg::LOAD_BYTE:          data_out = {{24{byte_sel[7]}}, byte_sel};
            mem_access_pkg::LOAD_BYTE_UNSIGNED: data_out = {24'd0, byte_sel};
            mem_access_pkg::LOAD_HALF,
            mem_access_pkg::LOAD_HALF_UNSIGNED: begin
                if (in_word_offset[0]) begin
                    misaligned = 1'b1;
                end else if (load_type == mem_access_pkg::LOAD_HALF) begin
                    data_out = {{16{half_sel[15]}}, half_sel};
                end else begin
                    data_out = {16'd0, half_sel};
                end
            end
            mem_access_pkg::LOAD_WORD: begin
                misaligned = in_word_offset != 2'd0;
                // Only whole aligned words come through
                data_out   = misaligned ? '0 : data_in;
            end
            default: unknown_type = 1'b1;
        endcase
    end

endmodule

/* store_align.sv */
`timescale 1ns/10ps

module store_align (
    input  logic [1:0]                 in_word_offset,
    input  mem_access_pkg::store_type_t store_type,
    input  logic [31:0]                data_in,
    output logic [31:0]                data_out,
    output logic [3:0]                 byte_mask,
    output logic                       misaligned,
    output logic                       unknown_type
);

    always_comb begin
        data_out     = data_in;
        byte_mask    = 4'b0000;
        misaligned   = 1'b0;
        unknown_type = 1'b0;
        case (store_type)
            mem_access_pkg::STORE_BYTE: begin
                data_out  = {4{data_in[7:0]}};
                byte_mask = 4'b0001 << in_word_offset;
            end
            mem_access_pkg::STORE_HALF: begin
                data_out   = {2{data_in[15:0]}};
                misaligned = in_word_offset[0];
                if (!misaligned) begin
                    byte_mask = 4'b0011 << in_word_offset;
                end
            end
            mem_access_pkg::STORE_WORD: begin
                misaligned = in_word_offset != 2'd0;
                if (!misaligned) begin
                    byte_mask = 4'b1111;
                end
            end
            // Unknown store leaves the mask empty
            default: unknown_type = 1'b1;
        endcase
    end

endmodule

/* cache_ctrl.sv */
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module cache_ctrl (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  mem_access_pkg::core_req_t                  core_req,
    input  logic                                       flush,
    output mem_access_pkg::core_rsp_t                  core_rsp,
    output logic                                       flushing,
    output logic                                       flush_done,
    output mem_access_pkg::core_req_t                  os_req,
    output logic [2**`L1_WAYS_W-1:0]                   data_rd_en,
    output logic [2**`L1_WAYS_W-1:0]                   tag_rd_en,
    output logic [`L1_LANES_W+`L1_OFFSET_W-1:0]        data_rd_addr,
    input  logic [2**`L1_WAYS_W-1:0][31:0]             data_rd_data,
    input  cache_geom_pkg::tag_t [2**`L1_WAYS_W-1:0]   tag_rd_data,
    output logic [2**`L1_WAYS_W-1:0]                   data_wr_en,
    output logic [`L1_LANES_W+`L1_OFFSET_W-1:0]        data_wr_addr,
    output logic [31:0]                                data_wr_data,
    output logic [2**`L1_WAYS_W-1:0]                   tag_wr_en,
    output cache_geom_pkg::tag_t                       tag_wr_data,
    input  logic [31:0]                                store_word,
    input  logic [3:0]                                 store_mask,
    input  logic [1:0]                                 store_flags,
    output logic [31:0]                                load_word,
    input  logic [31:0]                                load_result,
    input  logic [1:0]                                 load_flags,
    output mem_access_pkg::mem_cmd_t                   mem_cmd,
    input  mem_access_pkg::mem_rsp_t                   mem_rsp
);

    localparam int WAYS  = 2 ** `L1_WAYS_W;
    localparam int LANES = 2 ** `L1_LANES_W;

    cache_geom_pkg::ctrl_state_t            state;
    cache_geom_pkg::ctrl_state_t            return_state;
    cache_geom_pkg::line_state_t [WAYS-1:0] line_st [LANES];
    cache_geom_pkg::addr_fields_t           req_addr;
    cache_geom_pkg::addr_fields_t           os_addr;
    cache_geom_pkg::way_t                   rr_way;
    cache_geom_pkg::way_t                   cur_way;
    cache_geom_pkg::way_t                   hit_way;
    cache_geom_pkg::way_t                   fwd_way;
    cache_geom_pkg::lane_t                  cur_lane;
    cache_geom_pkg::offset_t                word_cnt;

    logic        os_active;
    logic        primed;
    logic        hit;
    logic        accept;
    logic        start_flush;
    logic        store_hit;
    logic        beat;
    logic        last_word;
    logic        victim_dirty;
    logic        sweep_dirty;
    logic        fwd_valid;
    logic [31:0] fwd_data;
    logic [31:0] merged;

    assign req_addr = core_req.addr;
    assign os_addr  = os_req.addr;

    assign core_rsp.stall = state != cache_geom_pkg::ST_IDLE || (os_active && !hit);
    assign core_rsp.done  = state == cache_geom_pkg::ST_IDLE && os_active && hit;
    assign core_rsp.load_data = load_result;
    assign {core_rsp.load_misaligned, core_rsp.load_unknown_type}   = load_flags;
    assign {core_rsp.store_misaligned, core_rsp.store_unknown_type} = store_flags;

    assign accept = state == cache_geom_pkg::ST_IDLE && (core_req.load || core_req.store)
                    && !flush && !core_rsp.stall;
    assign start_flush = state == cache_geom_pkg::ST_IDLE && flush && !core_rsp.stall;
    assign store_hit   = core_rsp.done && os_req.store;
    assign beat = state == cache_geom_pkg::ST_REFILL && mem_rsp.read_data_valid
                  && !mem_rsp.waitrequest;
    assign last_word    = word_cnt == '1;
    assign victim_dirty = line_st[os_addr.lane][rr_way].valid && line_st[os_addr.lane][rr_way].dirty;
    assign sweep_dirty  = line_st[cur_lane][cur_way].valid && line_st[cur_lane][cur_way].dirty;
    assign flush_done   = state == cache_geom_pkg::ST_FLUSH_ALL && !sweep_dirty
                          && cur_lane == '1 && cur_way == '1;

    // Lowest matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (line_st[os_addr.lane][w].valid && tag_rd_data[w] == os_addr.tag) begin
                hit     = 1'b1;
                hit_way = cache_geom_pkg::way_t'(w);
            end
        end
    end

    // RAM read misses a store to the same word in the previous cycle
    assign load_word = (fwd_valid && fwd_way == hit_way) ? fwd_data : data_rd_data[hit_way];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = store_mask[b] ? store_word[8*b +: 8] : load_word[8*b +: 8];
        end
    end

    // RAM ports and memory command
    always_comb begin
        data_rd_en   = '0;
        tag_rd_en    = '0;
        data_rd_addr = {req_addr.lane, req_addr.offset};
        data_wr_en   = '0;
        tag_wr_en    = '0;
        data_wr_addr = {os_addr.lane, os_addr.offset};
        data_wr_data = merged;
        tag_wr_data  = os_addr.tag;
        mem_cmd.addr        = {os_addr.tag, cur_lane, {`L1_OFFSET_W{1'b0}}, 2'b00};
        mem_cmd.burst_count = (`L1_OFFSET_W+1)'(2 ** `L1_OFFSET_W);
        mem_cmd.read        = 1'b0;
        mem_cmd.write       = 1'b0;
        mem_cmd.write_data  = data_rd_data[cur_way];
        mem_cmd.byte_enable = 4'b1111;
        case (state)
            cache_geom_pkg::ST_IDLE: begin
                data_rd_en          = {WAYS{accept}};
                tag_rd_en           = {WAYS{accept}};
                data_wr_en[hit_way] = store_hit;
            end
            cache_geom_pkg::ST_WRITEBACK: begin
                // Word on the bus is word_cnt, the next one is fetched behind it
                data_rd_addr = {cur_lane, primed ? word_cnt + 1'b1 : word_cnt};
                data_rd_en[cur_way] = !primed || !mem_rsp.waitrequest;
                tag_rd_en[cur_way]  = !primed;
                mem_cmd.addr  = {tag_rd_data[cur_way], cur_lane, {`L1_OFFSET_W{1'b0}}, 2'b00};
                mem_cmd.write = primed;
            end
            cache_geom_pkg::ST_REFILL: begin
                data_wr_addr        = {cur_lane, word_cnt};
                data_wr_data        = mem_rsp.read_data;
                data_wr_en[cur_way] = beat;
                tag_wr_en[cur_way]  = !primed;
                mem_cmd.read        = !primed;
            end
            default: ;
        endcase
    end

    // Output stage payload
    always_ff @(posedge clk) begin
        if (accept) begin
            os_req   <= core_req;
            fwd_data <= merged;
            fwd_way  <= hit_way;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= cache_geom_pkg::ST_IDLE;
            return_state <= cache_geom_pkg::ST_IDLE;
            for (int l = 0; l < LANES; l++) begin
                line_st[l] <= '0;
            end
            rr_way    <= '0;
            cur_way   <= '0;
            cur_lane  <= '0;
            word_cnt  <= '0;
            os_active <= 1'b0;
            primed    <= 1'b0;
            flushing  <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            case (state)
                cache_geom_pkg::ST_IDLE: begin
                    os_active <= accept;
                    fwd_valid <= accept && store_hit
                                 && {req_addr.lane, req_addr.offset} == data_wr_addr;
                    if (store_hit && |store_mask) begin
                        line_st[os_addr.lane][hit_way].dirty <= 1'b1;
                    end
                    if (start_flush) begin
                        state    <= cache_geom_pkg::ST_FLUSH_ALL;
                        flushing <= 1'b1;
                        cur_lane <= '0;
                        cur_way  <= '0;
                    end else if (os_active && !hit) begin
                        cur_lane     <= os_addr.lane;
                        cur_way      <= rr_way;
                        return_state <= cache_geom_pkg::ST_REFILL;
                        state <= victim_dirty ? cache_geom_pkg::ST_WRITEBACK
                                              : cache_geom_pkg::ST_REFILL;
                    end
                end
                cache_geom_pkg::ST_WRITEBACK: begin
                    if (!primed) begin
                        primed <= 1'b1;
                    end else if (!mem_rsp.waitrequest) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            line_st[cur_lane][cur_way].dirty <= 1'b0;
                            primed <= 1'b0;
                            state  <= return_state;
                        end
                    end
                end
                cache_geom_pkg::ST_REFILL: begin
                    if (!primed && !mem_rsp.waitrequest) begin
                        primed <= 1'b1;
                    end
                    if (beat) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            line_st[cur_lane][cur_way].valid <= 1'b1;
                            primed <= 1'b0;
                            rr_way <= rr_way + 1'b1;
                            state  <= cache_geom_pkg::ST_IDLE;
                        end
                    end
                end
                cache_geom_pkg::ST_FLUSH_ALL: begin
                    // Revisit the same line after its write-back, dirty is clear by then
                    if (sweep_dirty) begin
                        return_state <= cache_geom_pkg::ST_FLUSH_ALL;
                        state        <= cache_geom_pkg::ST_WRITEBACK;
                    end else begin
                        cur_lane <= cur_lane + 1'b1;
                        if (cur_lane == '1) begin
                            cur_way <= cur_way + 1'b1;
                            if (cur_way == '1) begin
                                state    <= cache_geom_pkg::ST_IDLE;
                                flushing <= 1'b0;
                            end
                        end
                    end
                end
                default: state <= cache_geom_pkg::ST_IDLE;
            endcase
        end
    end

    mem_read_write_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_cmd.read && mem_cmd.write)
    );

    done_stall_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(core_rsp.done && core_rsp.stall)
    );

endmodule

/* l1_cache.sv */
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module l1_cache (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_access_pkg::core_req_t core_req,
    input  logic                      flush,
    output mem_access_pkg::core_rsp_t core_rsp,
    output logic                      flushing,
    output logic                      flush_done,
    output mem_access_pkg::mem_cmd_t  mem_cmd,
    input  mem_access_pkg::mem_rsp_t  mem_rsp
);

    localparam int WAYS  = 2 ** `L1_WAYS_W;
    localparam int RAM_W = `L1_LANES_W + `L1_OFFSET_W;

    mem_access_pkg::core_req_t          os_req;
    logic [WAYS-1:0]                    data_rd_en;
    logic [WAYS-1:0]                    tag_rd_en;
    logic [WAYS-1:0]                    data_wr_en;
    logic [WAYS-1:0]                    tag_wr_en;
    logic [RAM_W-1:0]                   data_rd_addr;
    logic [RAM_W-1:0]                   data_wr_addr;
    logic [WAYS-1:0][31:0]              data_rd_data;
    cache_geom_pkg::tag_t [WAYS-1:0]    tag_rd_data;
    cache_geom_pkg::tag_t               tag_wr_data;
    logic [31:0]                        data_wr_data;
    logic [31:0]                        store_word;
    logic [31:0]                        load_word;
    logic [31:0]                        load_result;
    logic [3:0]                         store_mask;
    logic [1:0]                         store_flags;
    logic [1:0]                         load_flags;

    cache_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_req     (core_req),
        .flush        (flush),
        .core_rsp     (core_rsp),
        .flushing     (flushing),
        .flush_done   (flush_done),
        .os_req       (os_req),
        .data_rd_en   (data_rd_en),
        .tag_rd_en    (tag_rd_en),
        .data_rd_addr (data_rd_addr),
        .data_rd_data (data_rd_data),
        .tag_rd_data  (tag_rd_data),
        .data_wr_en   (data_wr_en),
        .data_wr_addr (data_wr_addr),
        .data_wr_data (data_wr_data),
        .tag_wr_en    (tag_wr_en),
        .tag_wr_data  (tag_wr_data),
        .store_word   (store_word),
        .store_mask   (store_mask),
        .store_flags  (store_flags),
        .load_word    (load_word),
        .load_result  (load_result),
        .load_flags   (load_flags),
        .mem_cmd      (mem_cmd),
        .mem_rsp      (mem_rsp)
    );

    load_align load_align_i (
        .in_word_offset (os_req.addr[1:0]),
        .load_type      (os_req.load_type),
        .data_in        (load_word),
        .data_out       (load_result),
        .misaligned     (load_flags[1]),
        .unknown_type   (load_flags[0])
    );

    store_align store_align_i (
        .in_word_offset (os_req.addr[1:0]),
        .store_type     (os_req.store_type),
        .data_in        (os_req.store_data),
        .data_out       (store_word),
        .byte_mask      (store_mask),
        .misaligned     (store_flags[1]),
        .unknown_type   (store_flags[0])
    );

    // Tag RAMs are addressed by the lane bits of the data RAM address
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        sync_ram #(
            .payload_t  (logic [31:0]),
            .ELEMENTS_W (RAM_W)
        ) data_ram_i (
            .clk           (clk),
            .read          (data_rd_en[w]),
            .read_address  (data_rd_addr),
            .read_data     (data_rd_data[w]),
            .write         (data_wr_en[w]),
            .write_address (data_wr_addr),
            .write_data    (data_wr_data)
        );

        sync_ram #(
            .payload_t  (cache_geom_pkg::tag_t),
            .ELEMENTS_W (`L1_LANES_W)
        ) tag_ram_i (
            .clk           (clk),
            .read          (tag_rd_en[w]),
            .read_address  (data_rd_addr[RAM_W-1 -: `L1_LANES_W]),
            .read_data     (tag_rd_data[w]),
            .write         (tag_wr_en[w]),
            .write_address (data_wr_addr[RAM_W-1 -: `L1_LANES_W]),
            .write_data    (tag_wr_data)
        );
    end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
    input  logic                     clk,
    input  mem_access_pkg::mem_cmd_t mem_cmd,
    output mem_access_pkg::mem_rsp_t mem_rsp
);

    logic [31:0] lfsr;
    logic [31:0] written_addr [$];
    logic [31:0] written_data [$];
    logic [31:0] rd_base;
    logic        gap_a;
    logic        gap_b;
    int          rd_left;
    int          rd_index;
    int          wr_index;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Latest write wins, untouched words follow the fill rule
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        for (int i = written_addr.size() - 1; i >= 0; i--) begin
            if (written_addr[i] == word_addr) begin
                return written_data[i];
            end
        end
        return word_addr ^ 32'h5a5a0000;
    endfunction

    function automatic void write_word(
        input logic [31:0] addr,
        input logic [31:0] data,
        input logic [3:0]  byte_enable
    );
        logic [31:0] merged;
        merged = read_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (byte_enable[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        written_addr.push_back({addr[31:2], 2'b00});
        written_data.push_back(merged);
    endfunction

    initial begin
        lfsr     = 32'h3e12a47b;
        mem_rsp  = '0;
        rd_base  = '0;
        rd_left  = 0;
        rd_index = 0;
        wr_index = 0;
    end

    // Handshakes complete on the rising edge
    always @(posedge clk) begin
        if (mem_rsp.read_data_valid) begin
            rd_index = rd_index + 1;
            rd_left  = rd_left - 1;
        end
        if (!mem_rsp.waitrequest && mem_cmd.read) begin
            rd_base  = mem_cmd.addr;
            rd_left  = mem_cmd.burst_count;
            rd_index = 0;
        end
        if (!mem_rsp.waitrequest && mem_cmd.write) begin
            // Burst address stays at the line base, the beat count gives the word
            write_word(mem_cmd.addr + 4 * wr_index, mem_cmd.write_data, mem_cmd.byte_enable);
            wr_index = wr_index + 1;
            if (wr_index == mem_cmd.burst_count) begin
                wr_index = 0;
            end
        end
    end

    // Wait states and read beats change on the falling edge
    always @(negedge clk) begin
        lfsr  = lfsr_step(lfsr);
        gap_a = lfsr[0];
        lfsr  = lfsr_step(lfsr);
        gap_b = lfsr[0];
        mem_rsp.waitrequest     = !gap_a && !gap_b;
        mem_rsp.read_data_valid = !mem_rsp.waitrequest && rd_left > 0;
        mem_rsp.read_data       = mem_rsp.read_data_valid ? read_word(rd_base + 4 * rd_index)
                                                          : '0;
    end

endmodule

/* cache_tb.sv */
`timescale 1ns/10ps

module cache_tb;

    localparam int OP_TIMEOUT    = 200;
    localparam int FLUSH_TIMEOUT = 20000;

    logic                      clk;
    logic                      rst_n;
    mem_access_pkg::core_req_t core_req;
    logic                      flush;
    mem_access_pkg::core_rsp_t core_rsp;
    logic                      flushing;
    logic                      flush_done;
    mem_access_pkg::mem_cmd_t  mem_cmd;
    mem_access_pkg::mem_rsp_t  mem_rsp;

    int               fd;
    int               fields;
    int               op_count;
    logic [8*8-1:0]   op;
    logic [8*8-1:0]   kind;
    logic [8*128-1:0] rest;
    logic [31:0]      addr;
    logic [31:0]      data;
    logic [31:0]      expected;

    l1_cache dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .flush      (flush),
        .core_rsp   (core_rsp),
        .flushing   (flushing),
        .flush_done (flush_done),
        .mem_cmd    (mem_cmd),
        .mem_rsp    (mem_rsp)
    );

    tb_mem_model mem_i (
        .clk     (clk),
        .mem_cmd (mem_cmd),
        .mem_rsp (mem_rsp)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(
        input logic [31:0] got,
        input logic [31:0] want,
        input string       what
    );
        if (got !== want) begin
            abort_run($sformatf("MISMATCH at %0t: %s, expected %h, got %h",
                                $time, what, want, got));
        end
    endtask

    // Halves need an even offset, words a zero offset
    function automatic logic misaligned_for(input logic [8*8-1:0] k, input logic [1:0] low);
        if (k == "w") begin
            return low != 2'd0;
        end
        if (k == "h" || k == "hu") begin
            return low[0];
        end
        return 1'b0;
    endfunction

    task automatic set_load_type(input logic [8*8-1:0] k);
        case (k)
            "b":     core_req.load_type = mem_access_pkg::LOAD_BYTE;
            "bu":    core_req.load_type = mem_access_pkg::LOAD_BYTE_UNSIGNED;
            "h":     core_req.load_type = mem_access_pkg::LOAD_HALF;
            "hu":    core_req.load_type = mem_access_pkg::LOAD_HALF_UNSIGNED;
            "w":     core_req.load_type = mem_access_pkg::LOAD_WORD;
            default: abort_run($sformatf("operation %0d has an unknown load type", op_count));
        endcase
    endtask

    task automatic set_store_type(input logic [8*8-1:0] k);
        case (k)
            "b":     core_req.store_type = mem_access_pkg::STORE_BYTE;
            "h":     core_req.store_type = mem_access_pkg::STORE_HALF;
            "w":     core_req.store_type = mem_access_pkg::STORE_WORD;
            default: abort_run($sformatf("operation %0d has an unknown store type", op_count));
        endcase
    endtask

    // Called on a falling edge, returns on the falling edge of the done cycle
    task automatic run_access(
        input logic           is_store,
        input logic [8*8-1:0] k,
        input logic [31:0]    a,
        input logic [31:0]    d,
        input logic [31:0]    want
    );
        int    waited;
        string name;
        waited = 0;
        name   = $sformatf("operation %0d, %s at %h", op_count, is_store ? "store" : "load", a);
        core_req.load       = !is_store;
        core_req.store      = is_store;
        core_req.addr       = a;
        core_req.store_data = d;
        if (is_store) begin
            set_store_type(k);
        end else begin
            set_load_type(k);
        end
        // Request stays up through any stall
        do begin
            @(posedge clk);
            @(negedge clk);
            waited++;
            if (waited > OP_TIMEOUT) begin
                abort_run($sformatf("%s did not finish within %0d cycles", name, OP_TIMEOUT));
            end
            // A miss shows up as stall right after acceptance
            if (waited == 1 && !core_rsp.done) begin
                check_value(core_rsp.stall, 1'b1, {name, ", stall after a miss"});
            end
        end while (!core_rsp.done);
        check_value(core_rsp.stall, 1'b0, {name, ", stall with done"});
        if (is_store) begin
            check_value(core_rsp.store_misaligned, misaligned_for(k, a[1:0]),
                        {name, ", store misaligned flag"});
            check_value(core_rsp.store_unknown_type, 1'b0, {name, ", store unknown flag"});
        end else begin
            check_value(core_rsp.load_data, want, {name, ", load data"});
            check_value(core_rsp.load_misaligned, misaligned_for(k, a[1:0]),
                        {name, ", load misaligned flag"});
            check_value(core_rsp.load_unknown_type, 1'b0, {name, ", load unknown flag"});
        end
        core_req.load  = 1'b0;
        core_req.store = 1'b0;
    endtask

    task automatic run_flush();
        int waited;
        waited = 0;
        flush  = 1'b1;
        @(posedge clk);
        @(negedge clk);
        flush = 1'b0;
        check_value(flushing, 1'b1, $sformatf("operation %0d, flushing raised", op_count));
        while (!flush_done) begin
            @(posedge clk);
            @(negedge clk);
            waited++;
            if (waited > FLUSH_TIMEOUT) begin
                abort_run($sformatf("operation %0d, flush did not finish within %0d cycles",
                                    op_count, FLUSH_TIMEOUT));
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_value(flushing, 1'b0, $sformatf("operation %0d, flushing dropped", op_count));
        check_value(flush_done, 1'b0, $sformatf("operation %0d, single flush_done", op_count));
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        core_req = '0;
        op_count = 0;
        fd = $fopen("cache_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("could not open cache_stimulus.txt");
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                fields = $fgets(rest, fd);
            end else begin
                fields = $fscanf(fd, "%s %h %h %h", kind, addr, data, expected);
                op_count++;
                if (fields != 4) begin
                    abort_run($sformatf("operation %0d in the stimulus file is incomplete",
                                        op_count));
                end
                if (op == "load") begin
                    run_access(1'b0, kind, addr, data, expected);
                end else if (op == "store") begin
                    run_access(1'b1, kind, addr, data, expected);
                end else if (op == "flush") begin
                    run_flush();
                end else if (op == "memcheck") begin
                    check_value(mem_i.read_word(addr), expected,
                                $sformatf("operation %0d, memory word at %h", op_count, addr));
                end else begin
                    abort_run($sformatf("operation %0d has an unknown opcode", op_count));
                end
            end
        end
        $fclose(fd);
        if (op_count == 0) begin
            abort_run("the stimulus file holds no operations");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* cache_stimulus.txt */
# op type address data expected, numbers in hex
# load types b bu h hu w, store types b h w, a dash where no type applies
# word load miss, then sub-word hits in the same line
load w 800080c4 00000000 da5a80c4
load b 800080c4 00000000 ffffffc4
load bu 800080c5 00000000 00000080
load b 800080c5 00000000 ffffff80
load b 800080c6 00000000 0000005a
load bu 800080c7 00000000 000000da
load h 800080c4 00000000 ffff80c4
load hu 800080c4 00000000 000080c4
load h 800080c6 00000000 ffffda5a
load hu 800080c6 00000000 0000da5a
load w 800080f8 00000000 da5a80f8
# byte store merge, memory keeps the old word
store b 800080c5 0000003c 00000000
load w 800080c4 00000000 da5a3cc4
memcheck - 800080c4 00000000 da5a80c4
# four more tags in lane 3 push the dirty line out
load w 000110c0 00000000 5a5b10c0
load w 000120c0 00000000 5a5b20c0
load w 000130c0 00000000 5a5b30c0
load w 000140c0 00000000 5a5b40c0
memcheck - 800080c4 00000000 da5a3cc4
memcheck - 800080f8 00000000 da5a80f8
load w 800080c4 00000000 da5a3cc4
load bu 800080c5 00000000 0000003c
# dirty lines in two lanes, then flush
store w 000120c8 12345678 00000000
store h 000130d2 0000beef 00000000
store b 800080f8 000000a5 00000000
store w 00020400 cafef00d 00000000
memcheck - 000120c8 00000000 5a5b20c8
flush - 00000000 00000000 00000000
memcheck - 000120c8 00000000 12345678
memcheck - 000130d0 00000000 beef30d0
memcheck - 800080f8 00000000 da5a80a5
memcheck - 00020400 00000000 cafef00d
memcheck - 000130c0 00000000 5a5b30c0
memcheck - 800080c4 00000000 da5a3cc4
load w 000120c8 00000000 12345678
# misaligned accesses leave the data alone
load w 000120ca 00000000 00000000
load h 000130d1 00000000 00000000
store w 000120c9 ffffffff 00000000
load w 000120c8 00000000 12345678
store h 000130d3 00001111 00000000
load w 000130d0 00000000 beef30d0
store h 000120ca 0000abcd 00000000
load hu 000120ca 00000000 0000abcd
load b 000120cb 00000000 ffffffab
flush - 00000000 00000000 00000000
memcheck - 000120c8 00000000 abcd5678
memcheck - 000130d0 00000000 beef30d0

/* l1_cache.f */
+incdir+.
cache_geom_pkg.sv
mem_access_pkg.sv
sync_ram.sv
load_align.sv
store_align.sv
cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
cache_tb.sv
